// ==== common/core_pkg.sv ====
/* core-wide widths and types */

package core_pkg;

  // ROB index, 128 entries
  localparam int robid_w = 7;

  // architectural destination register
  localparam int rd_w = 6;

  // datapath width
  localparam int xlen = 32;

  // exception cause code
  localparam int ecause_w = 5;

  typedef logic [robid_w-1:0] robid_t;

  typedef logic [rd_w-1:0] rd_t;

  typedef logic [xlen-1:0] data_t;

  // cause is only meaningful when the error bit is set
  typedef logic [ecause_w-1:0] ecause_t;

endpackage

// ==== common/wb_pkg.sv ====
/* writeback payloads and sources */

package wb_pkg;

  // stallable slots, rename excluded
  localparam int n_exec_src = 5;

  // rename only writes the low half of the register space
  localparam int rename_rd_w = core_pkg::rd_w - 1;

  // word-aligned result, low two bits implied zero
  localparam int rename_res_w = core_pkg::xlen - 2;

  // execution producer result
  typedef struct packed {
    logic              error;
    core_pkg::ecause_t ecause;
    core_pkg::robid_t  robid;
    core_pkg::rd_t     rd;
    core_pkg::data_t   result;
  } exec_wb_t;

  // rename result
  typedef struct packed {
    core_pkg::robid_t        robid;
    logic [rename_rd_w-1:0]  rd;
    logic [rename_res_w-1:0] result;
  } rename_wb_t;

  // bus payload seen by ROB and register file
  typedef struct packed {
    logic              error;
    core_pkg::ecause_t ecause;
    core_pkg::robid_t  robid;
    core_pkg::rd_t     rd;
    core_pkg::data_t   result;
  } cdb_t;

  // exec sources double as slot indices
  typedef enum logic [2:0] {
    src_lsq    = 3'd0,
    src_mcalu0 = 3'd1,
    src_mcalu1 = 3'd2,
    src_scalu0 = 3'd3,
    src_scalu1 = 3'd4,
    src_rename = 3'd5
  } wb_src_e;

  // highest priority first
  localparam wb_src_e wb_prio_order [n_exec_src+1] = '{
    src_rename,
    src_lsq,
    src_mcalu0,
    src_mcalu1,
    src_scalu0,
    src_scalu1
  };

endpackage

// ==== wb/wb_slot.sv ====
/* writeback holding slot */

`timescale 1ns/1ps

module wb_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,

  // capture enable, low while the held item waits
  input  logic     load_en,
  input  logic     in_valid,
  input  payload_t in_data,

  output logic     occupied,
  output payload_t data
);

  // valid bit, flush has priority over a load
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      occupied <= 1'b0;
    end else if (load_en) begin
      occupied <= in_valid;
    end
  end

  // payload follows the same enable
  always_ff @(posedge clk) begin
    if (load_en) begin
      data <= in_data;
    end
  end

endmodule

// ==== wb/wb_arbiter.sv ====
/* fixed-priority writeback select */

`timescale 1ns/1ps

module wb_arbiter (
  // registered rename result
  input  logic                          rename_valid,
  input  wb_pkg::rename_wb_t            rename_data,

  // occupied exec slots
  input  logic [wb_pkg::n_exec_src-1:0] slot_valid,
  input  wb_pkg::exec_wb_t              slot_data [wb_pkg::n_exec_src],

  // one-hot, exec slots only
  output logic [wb_pkg::n_exec_src-1:0] grant,

  output logic                          wb_valid,
  output wb_pkg::cdb_t                  wb_data
);

  import wb_pkg::*;

  logic                  found;
  logic                  rename_sel;
  logic [n_exec_src-1:0] pick;
  exec_wb_t              exec_sel;

  // walk the order, first occupied source wins
  always_comb begin
    found      = 1'b0;
    rename_sel = 1'b0;
    pick       = '0;
    for (int i = 0; i <= n_exec_src; i++) begin
      if (!found) begin
        if (wb_prio_order[i] == src_rename) begin
          if (rename_valid) begin
            rename_sel = 1'b1;
            found      = 1'b1;
          end
        end else if (slot_valid[wb_prio_order[i]]) begin
          pick[wb_prio_order[i]] = 1'b1;
          found                  = 1'b1;
        end
      end
    end
  end

  // one-hot payload mux, zero when nothing picked
  always_comb begin
    exec_sel = '0;
    for (int i = 0; i < n_exec_src; i++) begin
      if (pick[i]) begin
        exec_sel = slot_data[i];
      end
    end
  end

  assign grant    = pick;
  assign wb_valid = found;

  always_comb begin
    wb_data = '0;
    if (rename_sel) begin
      // rename never faults
      wb_data.error  = 1'b0;
      wb_data.ecause = '0;
      wb_data.robid  = rename_data.robid;
      wb_data.rd     = {1'b0, rename_data.rd};
      wb_data.result = {rename_data.result, 2'b00};
    end else begin
      wb_data.error  = exec_sel.error;
      wb_data.ecause = exec_sel.ecause;
      wb_data.robid  = exec_sel.robid;
      wb_data.rd     = exec_sel.rd;
      wb_data.result = exec_sel.result;
    end
  end

endmodule

// ==== wb/wb_cdb.sv ====
/* writeback common data bus */

`timescale 1ns/1ps

module wb_cdb (
  input  logic               clk,
  input  logic               reset,
  input  logic               rob_flush,

  // rename, never stalls
  input  logic               rename_valid,
  input  wb_pkg::rename_wb_t rename_data,

  input  logic               scalu0_valid,
  input  wb_pkg::exec_wb_t   scalu0_data,
  output logic               scalu0_stall,

  input  logic               scalu1_valid,
  input  wb_pkg::exec_wb_t   scalu1_data,
  output logic               scalu1_stall,

  input  logic               mcalu0_valid,
  input  wb_pkg::exec_wb_t   mcalu0_data,
  output logic               mcalu0_stall,

  input  logic               mcalu1_valid,
  input  wb_pkg::exec_wb_t   mcalu1_data,
  output logic               mcalu1_stall,

  input  logic               lsq_valid,
  input  wb_pkg::exec_wb_t   lsq_data,
  output logic               lsq_stall,

  // csr goes through the scalu0 slot
  input  logic               csr_valid,
  input  wb_pkg::exec_wb_t   csr_data,

  output logic               wb_valid,
  output wb_pkg::cdb_t       wb_data
);

  import wb_pkg::*;

  logic                  rename_occ;
  rename_wb_t            rename_q;

  logic [n_exec_src-1:0] in_valid;
  exec_wb_t              in_data [n_exec_src];
  logic [n_exec_src-1:0] load_en;
  logic [n_exec_src-1:0] occupied;
  exec_wb_t              slot_q [n_exec_src];
  logic [n_exec_src-1:0] grant;
  logic [n_exec_src-1:0] stall;

  // csr wins the shared slot, upstream keeps them exclusive
  assign in_valid[src_scalu0] = scalu0_valid | csr_valid;
  assign in_data[src_scalu0]  = csr_valid ? csr_data : scalu0_data;

  assign in_valid[src_scalu1] = scalu1_valid;
  assign in_data[src_scalu1]  = scalu1_data;

  assign in_valid[src_mcalu0] = mcalu0_valid;
  assign in_data[src_mcalu0]  = mcalu0_data;

  assign in_valid[src_mcalu1] = mcalu1_valid;
  assign in_data[src_mcalu1]  = mcalu1_data;

  assign in_valid[src_lsq]    = lsq_valid;
  assign in_data[src_lsq]     = lsq_data;

  // rename register reloads every cycle
  wb_slot #(
    .payload_t(rename_wb_t)
  ) u_rename (
    .clk      (clk),
    .reset    (reset),
    .flush    (rob_flush),
    .load_en  (1'b1),
    .in_valid (rename_valid),
    .in_data  (rename_data),
    .occupied (rename_occ),
    .data     (rename_q)
  );

  for (genvar i = 0; i < n_exec_src; i++) begin : g_slot
    wb_slot #(
      .payload_t(exec_wb_t)
    ) u_slot (
      .clk      (clk),
      .reset    (reset),
      .flush    (rob_flush),
      .load_en  (load_en[i]),
      .in_valid (in_valid[i]),
      .in_data  (in_data[i]),
      .occupied (occupied[i]),
      .data     (slot_q[i])
    );
  end

  wb_arbiter u_arbiter (
    .rename_valid (rename_occ),
    .rename_data  (rename_q),
    .slot_valid   (occupied),
    .slot_data    (slot_q),
    .grant        (grant),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data)
  );

  // held and not granted means the producer must wait
  assign stall   = occupied & ~grant;
  assign load_en = ~stall;

  assign lsq_stall    = stall[src_lsq];
  assign mcalu0_stall = stall[src_mcalu0];
  assign mcalu1_stall = stall[src_mcalu1];
  assign scalu0_stall = stall[src_scalu0];
  assign scalu1_stall = stall[src_scalu1];

endmodule

// ==== tests/wb_model.svh ====
/* writeback reference model and compare tasks */

`ifndef wb_model_svh
`define wb_model_svh

// exec slots below rename, highest first
localparam int exec_order [n_exec_src] = '{
  src_lsq,
  src_mcalu0,
  src_mcalu1,
  src_scalu0,
  src_scalu1
};

logic [n_exec_src-1:0] model_occ = '0;
exec_wb_t              model_data [n_exec_src];
logic                  model_ren_occ = 1'b0;
rename_wb_t            model_ren_data;

int bus_errors   = 0;
int stall_errors = 0;
int count_errors = 0;

// no fault, top rd bit zero, word-aligned result
function automatic cdb_t widen_rename(input rename_wb_t r);
  cdb_t c;
  c        = '0;
  c.robid  = r.robid;
  c.rd     = {1'b0, r.rd};
  c.result = {r.result, 2'b00};
  return c;
endfunction

function automatic cdb_t exec_to_cdb(input exec_wb_t e);
  cdb_t c;
  c.error  = e.error;
  c.ecause = e.ecause;
  c.robid  = e.robid;
  c.rd     = e.rd;
  c.result = e.result;
  return c;
endfunction

// bus and stalls from the current slot contents
task automatic predict_outputs(output logic v, output cdb_t d,
                               output logic [n_exec_src-1:0] st);
  logic [n_exec_src-1:0] g;
  g = '0;
  v = 1'b0;
  d = '0;
  if (model_ren_occ) begin
    v = 1'b1;
    d = widen_rename(model_ren_data);
  end else begin
    for (int k = 0; k < n_exec_src; k++) begin
      if (!v && model_occ[exec_order[k]]) begin
        v                = 1'b1;
        g[exec_order[k]] = 1'b1;
        d                = exec_to_cdb(model_data[exec_order[k]]);
      end
    end
  end
  st = model_occ & ~g;
endtask

// one clock edge; counts items lost to a flush
task automatic update_slots(input logic flush, input logic ren_v, input rename_wb_t ren_d,
                            input logic [n_exec_src-1:0] in_v,
                            input exec_wb_t in_d [n_exec_src], output int lost);
  logic                  v;
  cdb_t                  d;
  logic [n_exec_src-1:0] st;
  lost = 0;
  predict_outputs(v, d, st);
  if (flush) begin
    for (int i = 0; i < n_exec_src; i++) begin
      // held items and items accepted at this edge
      if (st[i] || (in_v[i] && !st[i])) begin
        lost++;
      end
    end
    if (ren_v) begin
      lost++;
    end
    model_occ     = '0;
    model_ren_occ = 1'b0;
  end else begin
    model_ren_occ  = ren_v;
    model_ren_data = ren_d;
    for (int i = 0; i < n_exec_src; i++) begin
      if (!st[i]) begin
        model_occ[i]  = in_v[i];
        model_data[i] = in_d[i];
      end
    end
  end
endtask

task automatic check_cdb(input logic act_v, input cdb_t act,
                         input logic want_v, input cdb_t want);
  if (act_v !== want_v || act !== want) begin
    bus_errors++;
    $display("ERROR at %0t: bus valid %b data %h, expected valid %b data %h",
             $time, act_v, act, want_v, want);
  end
endtask

task automatic check_stall(input logic [n_exec_src-1:0] act,
                           input logic [n_exec_src-1:0] want);
  if (act !== want) begin
    stall_errors++;
    $display("ERROR at %0t: stalls %b, expected %b", $time, act, want);
  end
endtask

task automatic compare_counts(input string what, input int act, input int want);
  if (act != want) begin
    count_errors++;
    $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, act, want);
  end
endtask

`endif

// ==== tests/tb_wb_cdb.sv ====
/* writeback bus testbench */

`timescale 1ns/1ps

module tb_wb_cdb;

  import core_pkg::*;
  import wb_pkg::*;

  localparam int reset_cycles   = 8;
  localparam int stim_cycles    = 4000;
  localparam int drain_cycles   = 50;
  localparam int timeout_cycles = 2 * stim_cycles + drain_cycles;

  logic                  clk;
  logic                  reset;
  logic                  rob_flush;
  logic                  rename_valid;
  rename_wb_t            rename_data;
  logic [n_exec_src-1:0] src_valid;
  exec_wb_t              src_data [n_exec_src];
  logic                  csr_valid;
  exec_wb_t              csr_data;
  wire [n_exec_src-1:0]  stall_out;
  logic                  wb_valid;
  cdb_t                  wb_data;

  // stalls seen during the cycle, acted on at the next edge
  logic [n_exec_src-1:0] stall_seen = '0;

  int taken       = 0;
  int emitted     = 0;
  int dropped     = 0;
  int cycle_count = 0;

  `include "wb_model.svh"

  wb_cdb uut (
    .clk          (clk),
    .reset        (reset),
    .rob_flush    (rob_flush),
    .rename_valid (rename_valid),
    .rename_data  (rename_data),
    .scalu0_valid (src_valid[src_scalu0]),
    .scalu0_data  (src_data[src_scalu0]),
    .scalu0_stall (stall_out[src_scalu0]),
    .scalu1_valid (src_valid[src_scalu1]),
    .scalu1_data  (src_data[src_scalu1]),
    .scalu1_stall (stall_out[src_scalu1]),
    .mcalu0_valid (src_valid[src_mcalu0]),
    .mcalu0_data  (src_data[src_mcalu0]),
    .mcalu0_stall (stall_out[src_mcalu0]),
    .mcalu1_valid (src_valid[src_mcalu1]),
    .mcalu1_data  (src_data[src_mcalu1]),
    .mcalu1_stall (stall_out[src_mcalu1]),
    .lsq_valid    (src_valid[src_lsq]),
    .lsq_data     (src_data[src_lsq]),
    .lsq_stall    (stall_out[src_lsq]),
    .csr_valid    (csr_valid),
    .csr_data     (csr_data),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic exec_wb_t random_exec_item();
    exec_wb_t    e;
    logic [31:0] r;
    r        = $urandom;
    e.error  = r[31];
    e.ecause = ecause_t'(r >> 20);
    e.robid  = robid_t'(r >> 8);
    e.rd     = rd_t'(r);
    e.result = $urandom;
    return e;
  endfunction

  function automatic rename_wb_t random_rename_item();
    rename_wb_t  n;
    logic [31:0] r;
    r        = $urandom;
    n.robid  = robid_t'(r >> 8);
    n.rd     = rename_rd_w'(r);
    n.result = rename_res_w'($urandom);
    return n;
  endfunction

  // new item only after the previous one was taken
  task automatic offer_items(input logic offer);
    int unsigned pick;
    for (int i = 0; i < n_exec_src; i++) begin
      if (i != src_scalu0 && !(src_valid[i] && stall_seen[i])) begin
        src_valid[i] <= offer && ($urandom_range(99) < 45);
        src_data[i]  <= random_exec_item();
      end
    end
    // csr only when scalu0 has nothing to send
    if (!((src_valid[src_scalu0] || csr_valid) && stall_seen[src_scalu0])) begin
      pick                  = $urandom_range(9);
      src_valid[src_scalu0] <= offer && (pick < 4);
      csr_valid             <= offer && (pick == 4);
      src_data[src_scalu0]  <= random_exec_item();
      csr_data              <= random_exec_item();
    end
    rename_valid <= offer && ($urandom_range(99) < 25);
    rename_data  <= random_rename_item();
    rob_flush    <= offer && ($urandom_range(199) == 0);
  endtask

  task automatic step_cycle(input logic offer);
    logic [n_exec_src-1:0] mrg_v;
    exec_wb_t              mrg_d [n_exec_src];
    int                    lost;
    for (int i = 0; i < n_exec_src; i++) begin
      mrg_v[i] = src_valid[i];
      mrg_d[i] = src_data[i];
    end
    mrg_v[src_scalu0] = src_valid[src_scalu0] | csr_valid;
    if (csr_valid) begin
      mrg_d[src_scalu0] = csr_data;
    end
    if (!reset) begin
      for (int i = 0; i < n_exec_src; i++) begin
        if (mrg_v[i] && !stall_seen[i]) begin
          taken++;
        end
      end
      if (rename_valid) begin
        taken++;
      end
    end
    update_slots(reset || rob_flush, rename_valid, rename_data, mrg_v, mrg_d, lost);
    if (!reset) begin
      dropped += lost;
    end
    offer_items(offer);
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    logic                  want_v;
    cdb_t                  want_d;
    logic [n_exec_src-1:0] want_st;
    if (!reset) begin
      predict_outputs(want_v, want_d, want_st);
      check_cdb(wb_valid, wb_data, want_v, want_d);
      check_stall(stall_out, want_st);
      if (wb_valid === 1'b1) begin
        emitted++;
      end
    end
    stall_seen = stall_out;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic idle;
    void'($urandom(32'hb44b8ff5));
    reset        <= 1'b1;
    rob_flush    <= 1'b0;
    rename_valid <= 1'b0;
    rename_data  <= '0;
    src_valid    <= '0;
    csr_valid    <= 1'b0;
    csr_data     <= '0;
    for (int i = 0; i < n_exec_src; i++) begin
      src_data[i] <= '0;
    end
    for (int c = 0; c < reset_cycles; c++) begin
      @(posedge clk);
      step_cycle(1'b0);
    end
    reset <= 1'b0;
    for (int c = 0; c < stim_cycles; c++) begin
      @(posedge clk);
      step_cycle(1'b1);
    end
    // let held items drain out
    do begin
      @(posedge clk);
      idle = !rename_valid && !csr_valid && (src_valid == '0) &&
             (model_occ == '0) && !model_ren_occ;
      if (!idle) begin
        step_cycle(1'b0);
      end
    end while (!idle);
    compare_counts("taken items", taken, emitted + dropped);
    $display("bus errors %0d, stall errors %0d, count errors %0d (taken %0d, emitted %0d, dropped %0d)",
             bus_errors, stall_errors, count_errors, taken, emitted, dropped);
    if (bus_errors + stall_errors + count_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tests
common/core_pkg.sv
common/wb_pkg.sv
wb/wb_slot.sv
wb/wb_arbiter.sv
wb/wb_cdb.sv
tests/tb_wb_cdb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log
build=obj_dir

rm -rf "$build" "$log"

verilator --binary --top-module tb_wb_cdb -f verilog.f -Mdir "$build" -o sim_wb_cdb

./"$build"/sim_wb_cdb | tee "$log"

if grep -q "Finished with errors" "$log"; then
  echo "simulation failed, see $log"
  exit 1
fi

echo "simulation passed"
